//--- riscv_id_ex.f
+incdir+test
verilog/riscv_pkg.sv
verilog/riscv_id_imm.sv
verilog/riscv_id_stage.sv
verilog/riscv_ex_agu.sv
verilog/riscv_id_ex_top.sv
test/tb_riscv_id_ex.sv

//--- Makefile
SRCS = verilog/riscv_pkg.sv verilog/riscv_id_imm.sv verilog/riscv_id_stage.sv \
       verilog/riscv_ex_agu.sv verilog/riscv_id_ex_top.sv \
       test/tb_riscv_id_ex.sv test/tb_riscv_ref.svh

.PHONY: all run clean

all: run

obj_dir/Vtb_riscv_id_ex: riscv_id_ex.f $(SRCS)
	verilator --binary --timing --assert -f riscv_id_ex.f \
		--top-module tb_riscv_id_ex -Mdir obj_dir

run: obj_dir/Vtb_riscv_id_ex
	./obj_dir/Vtb_riscv_id_ex | tee sim.log
	grep -q '^>>> PASS$$' sim.log

clean:
	rm -rf obj_dir sim.log

//--- test/tb_riscv_ref.svh
`ifndef TB_RISCV_REF_SVH
`define TB_RISCV_REF_SVH

// class of an instruction word by its opcode
function automatic inst_kind_t decode_kind(input inst_t word);
    case (word[6:0])
        OPC_LUI:    return KIND_LUI;
        OPC_AUIPC:  return KIND_AUIPC;
        OPC_JAL:    return KIND_JAL;
        OPC_JALR:   return KIND_JALR;
        OPC_BRANCH: return KIND_BRANCH;
        OPC_LOAD:   return KIND_LOAD;
        OPC_STORE:  return KIND_STORE;
        OPC_OP_IMM: return KIND_OP_IMM;
        OPC_OP:     return KIND_OP;
        OPC_FENCE:  return KIND_FENCE;
        OPC_SYS:    return KIND_SYS;
        default:    return KIND_ILLEGAL;
    endcase
endfunction

// field left aligned so that an arithmetic shift sign extends it
function automatic data_t sign_extended_imm(input inst_t word);
    case (word[6:0])
        OPC_JALR, OPC_LOAD, OPC_OP_IMM:
            return $signed({word[31:20], 20'd0}) >>> 20;
        OPC_STORE:
            return $signed({word[31:25], word[11:7], 20'd0}) >>> 20;
        OPC_BRANCH:
            return $signed({word[31], word[7], word[30:25], word[11:8], 20'd0}) >>> 19;
        OPC_JAL:
            return $signed({word[31], word[19:12], word[20], word[30:21], 12'd0}) >>> 11;
        OPC_LUI, OPC_AUIPC:
            return {word[31:12], 12'd0};
        default:
            return 32'd0;
    endcase
endfunction

function automatic data_t control_target(input inst_kind_t kind, input data_t imm,
                                         input data_t pc_v, input data_t a);
    case (kind)
        KIND_JAL, KIND_BRANCH: return pc_v + imm;
        KIND_JALR:             return (a + imm) & ~32'd1;
        default:               return 32'd0;
    endcase
endfunction

function automatic logic branch_decision(input inst_kind_t kind, input logic [2:0] f3,
                                         input data_t a, input data_t b);
    int sa;
    int sb;
    sa = a;
    sb = b;
    if (kind == KIND_JAL || kind == KIND_JALR) return 1'b1;
    if (kind != KIND_BRANCH) return 1'b0;
    case (f3)
        F3_BEQ:  return a == b;
        F3_BNE:  return a != b;
        F3_BLT:  return sa < sb;
        F3_BGE:  return sa >= sb;
        F3_BLTU: return a < b;
        F3_BGEU: return a >= b;
        default: return 1'b0;
    endcase
endfunction

function automatic data_t result_value(input inst_kind_t kind, input data_t imm,
                                       input data_t pc_v, input data_t a);
    case (kind)
        KIND_LUI:              return imm;
        KIND_AUIPC:            return pc_v + imm;
        KIND_JAL, KIND_JALR:   return pc_v + 32'd4;
        KIND_LOAD, KIND_STORE: return a + imm;
        default:               return 32'd0;
    endcase
endfunction

`endif

//--- test/tb_riscv_id_ex.sv
`timescale 1ns/10ps

module tb_riscv_id_ex import riscv_pkg::*; ();

    `include "tb_riscv_ref.svh"

    typedef struct packed {
        inst_kind_t kind;
        reg_idx_t   rd;
        data_t      imm;
        data_t      target;
        logic       taken;
        data_t      value;
    } exp_rec_t;

    logic       clk = 1'b0;
    logic       reset;
    logic       inst_valid;
    inst_t      inst;
    data_t      pc;
    data_t      rs1_data;
    data_t      rs2_data;
    logic       out_valid;
    inst_kind_t out_kind;
    reg_idx_t   out_rd;
    data_t      out_imm;
    data_t      out_target;
    logic       out_taken;
    data_t      out_value;

    exp_rec_t    exp_q[$];
    string       name_q[$];
    exp_rec_t    expect_rec;
    string       test_name;
    logic [31:0] rng = 32'h4aa3;
    int          checked = 0;
    int          mismatches = 0;
    int          latency_errors = 0;
    int          other_errors = 0;

    riscv_id_ex_top #(.PIPE_STAGES_OUT(1'b1)) UUT (.*);

    always #5 clk = ~clk;

    // every strobe comes out exactly once and two cycles later
    latency_check: assert property (@(posedge clk) disable iff (reset)
        out_valid == $past(inst_valid, 2))
    else begin
        latency_errors++;
        $display("out_valid does not follow inst_valid by two cycles at %0t", $time);
    end

    function logic [31:0] rand32();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    function inst_t make_inst(input opcode_t opc);
        inst_t word;
        word = rand32();
        word[6:0] = opc;
        return word;
    endfunction

    function automatic opcode_t pick_opcode(input int sel);
        case (sel)
            0:       return OPC_LUI;
            1:       return OPC_AUIPC;
            2:       return OPC_JAL;
            3:       return OPC_JALR;
            4:       return OPC_BRANCH;
            5:       return OPC_LOAD;
            6:       return OPC_STORE;
            7:       return OPC_OP_IMM;
            8:       return OPC_OP;
            9:       return OPC_FENCE;
            10:      return OPC_SYS;
            default: return 7'b1011011;
        endcase
    endfunction

    task check_field(input string test, input string field, input data_t expected,
                     input data_t actual);
        assert (expected == actual)
        else begin
            mismatches++;
            $display("mismatch %s %s: expected %h, actual %h", test, field, expected, actual);
        end
    endtask

    // one strobe with its expected record queued in the same cycle
    task automatic send(input inst_t word, input data_t pc_v, input data_t a,
                        input data_t b, input string test);
        exp_rec_t rec;
        rec.kind   = decode_kind(word);
        rec.rd     = word[11:7];
        rec.imm    = sign_extended_imm(word);
        rec.target = control_target(rec.kind, rec.imm, pc_v, a);
        rec.taken  = branch_decision(rec.kind, word[14:12], a, b);
        rec.value  = result_value(rec.kind, rec.imm, pc_v, a);
        exp_q.push_back(rec);
        name_q.push_back(test);
        inst_valid = 1'b1;
        inst       = word;
        pc         = pc_v;
        rs1_data   = a;
        rs2_data   = b;
        @(posedge clk);
        #1;
        inst_valid = 1'b0;
    endtask

    task send_random(input opcode_t opc, input string test);
        send(make_inst(opc), rand32() & 32'hffff_fffc, rand32(), rand32(), test);
    endtask

    // payload keeps moving underneath the gap cycles
    task idle(input int cycles);
        repeat (cycles) begin
            inst = rand32();
            pc   = rand32();
            @(posedge clk);
            #1;
        end
    endtask

    // --------------------
    // scoreboard
    // --------------------
    always @(negedge clk) begin
        if (!reset && out_valid) begin
            if (exp_q.size() == 0) begin
                other_errors++;
                $display("out_valid is high with no instruction in flight");
            end else begin
                expect_rec = exp_q.pop_front();
                test_name  = name_q.pop_front();
                check_field(test_name, "kind", 32'(expect_rec.kind), 32'(out_kind));
                check_field(test_name, "rd", 32'(expect_rec.rd), 32'(out_rd));
                check_field(test_name, "imm", expect_rec.imm, out_imm);
                check_field(test_name, "target", expect_rec.target, out_target);
                check_field(test_name, "taken", 32'(expect_rec.taken), 32'(out_taken));
                check_field(test_name, "value", expect_rec.value, out_value);
                checked++;
            end
        end
    end

    initial begin
        inst_t word;
        data_t a;
        int    wait_cycles;
        reset      = 1'b1;
        inst_valid = 1'b0;
        inst       = '0;
        pc         = '0;
        rs1_data   = '0;
        rs2_data   = '0;
        repeat (5) @(posedge clk);
        #1;
        assert (out_valid == 1'b0)
        else begin
            other_errors++;
            $display("out_valid is high while reset is held");
        end
        reset = 1'b0;
        idle(4);

        // --------------------
        // every class with both signs
        // --------------------
        for (int i = 0; i < 12; i++) begin
            for (int n = 0; n < 6; n++) begin
                word = make_inst(pick_opcode(i));
                word[31] = (n < 3);
                send(word, rand32() & 32'hffff_fffc, rand32(), rand32(), "class_imm");
            end
            idle(1);
        end
        send(32'd0, 32'h0000_0100, rand32(), rand32(), "illegal_zero");
        send_random(7'b1111111, "illegal_ones");
        send_random(7'b0000111, "illegal_fp");

        // --------------------
        // jumps
        // --------------------
        word = make_inst(OPC_JALR);
        word[31:20] = 12'h7ff;
        send(word, 32'h0000_2000, 32'h0000_0100, rand32(), "jalr_odd_sum");
        word[31:20] = 12'h000;
        send(word, 32'h0000_2000, 32'h0000_1001, rand32(), "jalr_odd_base");
        word = make_inst(OPC_JAL);
        word[31] = 1'b1;
        send(word, 32'h0000_8000, rand32(), rand32(), "jal_back");

        // branches including the unused funct3 codes
        for (int f = 0; f < 8; f++) begin
            word = make_inst(OPC_BRANCH);
            word[14:12] = 3'(f);
            a = rand32();
            send(word, rand32() & 32'hffff_fffc, a, a, "branch_equal");
            send(word, 32'h0000_4000, a | 32'h8000_0000, a >> 1, "branch_neg_pos");
            send(word, 32'h0000_4000, a >> 1, a | 32'h8000_0000, "branch_pos_neg");
            send(word, 32'h0000_4000, rand32(), rand32(), "branch_random");
        end

        // --------------------
        // streaming
        // --------------------
        for (int n = 0; n < 24; n++) begin
            send_random(pick_opcode(int'(rand32() % 32'd12)), "stream");
        end
        for (int n = 0; n < 40; n++) begin
            send_random(pick_opcode(int'(rand32() % 32'd12)), "stream_gaps");
            idle(int'(rand32() % 32'd4));
        end

        wait_cycles = 0;
        while (exp_q.size() != 0 && wait_cycles < 20) begin
            @(posedge clk);
            wait_cycles++;
        end
        if (exp_q.size() != 0) begin
            other_errors++;
            $display("timeout with %0d instructions still in flight", exp_q.size());
        end
        idle(4);

        $display("checked %0d, mismatches %0d, latency errors %0d, other errors %0d",
                 checked, mismatches, latency_errors, other_errors);
        if (mismatches + latency_errors + other_errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

//--- verilog/riscv_id_ex_top.sv
`timescale 1ns/10ps

module riscv_id_ex_top import riscv_pkg::*; #(
    parameter bit PIPE_STAGES_OUT = 1'b1
) (
    input  logic       clk,
    input  logic       reset,

    input  logic       inst_valid,
    input  inst_t      inst,
    input  data_t      pc,
    input  data_t      rs1_data,
    input  data_t      rs2_data,

    output logic       out_valid,
    output inst_kind_t out_kind,
    output reg_idx_t   out_rd,
    output data_t      out_imm,
    output data_t      out_target,
    output logic       out_taken,
    output data_t      out_value
);

    // --------------------
    // decode to agu
    // --------------------
    logic       id_valid;
    inst_kind_t id_kind;
    logic [2:0] id_funct3;
    reg_idx_t   id_rd;
    data_t      id_imm;
    data_t      id_pc;
    data_t      id_rs1_data;
    data_t      id_rs2_data;

    riscv_id_stage riscv_id_stage_inst (
        .clk         (clk),
        .reset       (reset),
        .inst_valid  (inst_valid),
        .inst        (inst),
        .pc          (pc),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .id_valid    (id_valid),
        .id_kind     (id_kind),
        .id_funct3   (id_funct3),
        .id_rd       (id_rd),
        .id_imm      (id_imm),
        .id_pc       (id_pc),
        .id_rs1_data (id_rs1_data),
        .id_rs2_data (id_rs2_data)
    );

    riscv_ex_agu #(
        .PIPE_STAGES_OUT (PIPE_STAGES_OUT)
    ) riscv_ex_agu_inst (
        .clk         (clk),
        .reset       (reset),
        .id_valid    (id_valid),
        .id_kind     (id_kind),
        .id_funct3   (id_funct3),
        .id_rd       (id_rd),
        .id_imm      (id_imm),
        .id_pc       (id_pc),
        .id_rs1_data (id_rs1_data),
        .id_rs2_data (id_rs2_data),
        .out_valid   (out_valid),
        .out_kind    (out_kind),
        .out_rd      (out_rd),
        .out_imm     (out_imm),
        .out_target  (out_target),
        .out_taken   (out_taken),
        .out_value   (out_value)
    );

endmodule

//--- verilog/riscv_ex_agu.sv
`timescale 1ns/10ps

module riscv_ex_agu import riscv_pkg::*; #(
    parameter bit PIPE_STAGES_OUT = 1'b1
) (
    input  logic       clk,
    input  logic       reset,

    input  logic       id_valid,
    input  inst_kind_t id_kind,
    input  logic [2:0] id_funct3,
    input  reg_idx_t   id_rd,
    input  data_t      id_imm,
    input  data_t      id_pc,
    input  data_t      id_rs1_data,
    input  data_t      id_rs2_data,

    output logic       out_valid,
    output inst_kind_t out_kind,
    output reg_idx_t   out_rd,
    output data_t      out_imm,
    output data_t      out_target,
    output logic       out_taken,
    output data_t      out_value
);

    data_t pc_plus_imm;
    data_t rs1_plus_imm;
    data_t pc_plus_4;
    logic  rs_eq;
    logic  rs_lt;
    logic  rs_ltu;
    logic  branch_taken;
    data_t target_c;
    logic  taken_c;
    data_t value_c;

    // --------------------
    // shared adders
    // --------------------
    assign pc_plus_imm  = id_pc + id_imm;
    assign rs1_plus_imm = id_rs1_data + id_imm;
    assign pc_plus_4    = id_pc + data_t'(4);

    // one comparator set for all six branches
    assign rs_eq  = (id_rs1_data == id_rs2_data);
    assign rs_lt  = ($signed(id_rs1_data) < $signed(id_rs2_data));
    assign rs_ltu = (id_rs1_data < id_rs2_data);

    always_comb begin
        case (id_funct3)
            F3_BEQ:  branch_taken = rs_eq;
            F3_BNE:  branch_taken = !rs_eq;
            F3_BLT:  branch_taken = rs_lt;
            F3_BGE:  branch_taken = !rs_lt;
            F3_BLTU: branch_taken = rs_ltu;
            F3_BGEU: branch_taken = !rs_ltu;
            default: branch_taken = 1'b0;
        endcase
    end

    // --------------------
    // result select
    // --------------------
    always_comb begin
        target_c = '0;
        taken_c  = 1'b0;
        value_c  = '0;
        case (id_kind)
            KIND_LUI: begin
                value_c = id_imm;
            end
            KIND_AUIPC: begin
                value_c = pc_plus_imm;
            end
            KIND_JAL: begin
                target_c = pc_plus_imm;
                taken_c  = 1'b1;
                value_c  = pc_plus_4;
            end
            KIND_JALR: begin
                // lsb dropped per the ISA
                target_c = {rs1_plus_imm[DATA_WIDTH-1:1], 1'b0};
                taken_c  = 1'b1;
                value_c  = pc_plus_4;
            end
            KIND_BRANCH: begin
                target_c = pc_plus_imm;
                taken_c  = branch_taken;
            end
            KIND_LOAD, KIND_STORE: begin
                value_c = rs1_plus_imm;
            end
            default: begin
                // op, op_imm, fence, sys, illegal leave all zero
                value_c = '0;
            end
        endcase
    end

    // --------------------
    // output stage
    // --------------------
    generate
        if (PIPE_STAGES_OUT) begin : g_reg_out
            always_ff @(posedge clk) begin
                if (reset) begin
                    out_valid <= 1'b0;
                end else begin
                    out_valid <= id_valid;
                end
            end

            always_ff @(posedge clk) begin
                if (id_valid) begin
                    out_kind   <= id_kind;
                    out_rd     <= id_rd;
                    out_imm    <= id_imm;
                    out_target <= target_c;
                    out_taken  <= taken_c;
                    out_value  <= value_c;
                end
            end
        end else begin : g_comb_out
            assign out_valid  = id_valid;
            assign out_kind   = id_kind;
            assign out_rd     = id_rd;
            assign out_imm    = id_imm;
            assign out_target = target_c;
            assign out_taken  = taken_c;
            assign out_value  = value_c;
        end
    endgenerate

endmodule

//--- verilog/riscv_id_stage.sv
`timescale 1ns/10ps

module riscv_id_stage import riscv_pkg::*; (
    input  logic       clk,
    input  logic       reset,

    input  logic       inst_valid,
    input  inst_t      inst,
    input  data_t      pc,
    input  data_t      rs1_data,
    input  data_t      rs2_data,

    output logic       id_valid,
    output inst_kind_t id_kind,
    output logic [2:0] id_funct3,
    output reg_idx_t   id_rd,
    output data_t      id_imm,
    output data_t      id_pc,
    output data_t      id_rs1_data,
    output data_t      id_rs2_data
);

    opcode_t    opcode;
    logic [2:0] funct3;
    reg_idx_t   rd;
    inst_kind_t kind;
    data_t      imm;

    // --------------------
    // field extraction
    // --------------------
    assign opcode = inst[6:0];
    assign rd     = inst[11:7];
    assign funct3 = inst[14:12];

    riscv_id_imm riscv_id_imm_dec (
        .inst (inst),
        .imm  (imm)
    );

    // opcode to class
    always_comb begin
        case (opcode)
            OPC_LUI:    kind = KIND_LUI;
            OPC_AUIPC:  kind = KIND_AUIPC;
            OPC_JAL:    kind = KIND_JAL;
            OPC_JALR:   kind = KIND_JALR;
            OPC_BRANCH: kind = KIND_BRANCH;
            OPC_LOAD:   kind = KIND_LOAD;
            OPC_STORE:  kind = KIND_STORE;
            OPC_OP_IMM: kind = KIND_OP_IMM;
            OPC_OP:     kind = KIND_OP;
            OPC_FENCE:  kind = KIND_FENCE;
            OPC_SYS:    kind = KIND_SYS;
            default:    kind = KIND_ILLEGAL;
        endcase
    end

    // --------------------
    // output registers
    // --------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            id_valid <= 1'b0;
        end else begin
            id_valid <= inst_valid;
        end
    end

    // payload only moves on a strobe
    always_ff @(posedge clk) begin
        if (inst_valid) begin
            id_kind     <= kind;
            id_funct3   <= funct3;
            id_rd       <= rd;
            id_imm      <= imm;
            id_pc       <= pc;
            id_rs1_data <= rs1_data;
            id_rs2_data <= rs2_data;
        end
    end

endmodule

//--- verilog/riscv_id_imm.sv
`timescale 1ns/10ps

module riscv_id_imm import riscv_pkg::*; (
    input  inst_t inst,
    output data_t imm
);

    opcode_t opcode;
    data_t   imm_type_i;
    data_t   imm_type_s;
    data_t   imm_type_b;
    data_t   imm_type_u;
    data_t   imm_type_j;

    assign opcode = inst[6:0];

    // --------------------
    // formats
    // --------------------
    // sign bit is always inst[31]
    assign imm_type_i = {{(DATA_WIDTH-12){inst[31]}}, inst[31:20]};

    assign imm_type_s = {{(DATA_WIDTH-12){inst[31]}}, inst[31:25], inst[11:7]};

    // branch offset, halfword aligned
    assign imm_type_b = {
        {(DATA_WIDTH-13){inst[31]}},
        inst[31],
        inst[7],
        inst[30:25],
        inst[11:8],
        1'b0
    };

    // upper 20 bits, already full width
    assign imm_type_u = {inst[31:12], 12'b0};

    // jump offset, halfword aligned
    assign imm_type_j = {
        {(DATA_WIDTH-21){inst[31]}},
        inst[31],
        inst[19:12],
        inst[20],
        inst[30:21],
        1'b0
    };

    // --------------------
    // select by opcode
    // --------------------
    always_comb begin
        case (opcode)
            OPC_LUI,
            OPC_AUIPC:  imm = imm_type_u;
            OPC_JAL:    imm = imm_type_j;
            OPC_JALR,
            OPC_LOAD,
            OPC_OP_IMM: imm = imm_type_i;
            OPC_BRANCH: imm = imm_type_b;
            OPC_STORE:  imm = imm_type_s;
            // R-type, fence, system and unknown carry no immediate
            default:    imm = '0;
        endcase
    end

endmodule

//--- verilog/riscv_pkg.sv
package riscv_pkg;

    // --------------------
    // widths
    // --------------------
    localparam int DATA_WIDTH = 32;
    localparam int INST_WIDTH = 32;

    typedef logic [INST_WIDTH-1:0] inst_t;
    typedef logic [DATA_WIDTH-1:0] data_t;
    typedef logic [4:0]            reg_idx_t;
    typedef logic [6:0]            opcode_t;

    // --------------------
    // opcodes
    // --------------------
    localparam opcode_t OPC_LUI    = 7'b0110111;
    localparam opcode_t OPC_AUIPC  = 7'b0010111;
    localparam opcode_t OPC_JAL    = 7'b1101111;
    localparam opcode_t OPC_JALR   = 7'b1100111;
    localparam opcode_t OPC_BRANCH = 7'b1100011;
    localparam opcode_t OPC_LOAD   = 7'b0000011;
    localparam opcode_t OPC_STORE  = 7'b0100011;
    localparam opcode_t OPC_OP_IMM = 7'b0010011;
    localparam opcode_t OPC_OP     = 7'b0110011;
    localparam opcode_t OPC_FENCE  = 7'b0001111;
    localparam opcode_t OPC_SYS    = 7'b1110011;

    // instruction class seen by the later stages
    typedef enum logic [3:0] {
        KIND_LUI     = 4'd0,
        KIND_AUIPC   = 4'd1,
        KIND_JAL     = 4'd2,
        KIND_JALR    = 4'd3,
        KIND_BRANCH  = 4'd4,
        KIND_LOAD    = 4'd5,
        KIND_STORE   = 4'd6,
        KIND_OP_IMM  = 4'd7,
        KIND_OP      = 4'd8,
        KIND_FENCE   = 4'd9,
        KIND_SYS     = 4'd10,
        KIND_ILLEGAL = 4'd11
    } inst_kind_t;

    // --------------------
    // branch funct3
    // --------------------
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    // 010 and 011 are unused for branches
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

endpackage
